//--- soc_fpga_wrapper.f
hdl/soc_pkg.sv
hdl/reset_stretch.sv
hdl/uart_rx.sv
hdl/cmd_engine.sv
hdl/uart_tx.sv
hdl/soc_fpga_wrapper.sv
dv/tb_clk_gen.sv
dv/tb_soc_fpga_wrapper.sv

//--- Makefile
# Verilator build and run of the serial command wrapper testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_fpga_wrapper
FILELIST  ?= soc_fpga_wrapper.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= STATUS: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) $(VFLAGS) -f $(FILELIST)

# exit status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_soc_fpga_wrapper.sv
`timescale 1ns/1ps

module tb_soc_fpga_wrapper;

   localparam int BIT_CLKS = soc_pkg::BIT_CLKS;
   localparam int FRAME_CLKS = 10 * BIT_CLKS;
   localparam int RESP_TIMEOUT = 3 * FRAME_CLKS;
   localparam int QUIET_CLKS = 2 * FRAME_CLKS;
   localparam int RST_TIMEOUT = 200;
   localparam logic [3:0] OP_WR = 4'h1;
   localparam logic [3:0] OP_RD = 4'h2;

   // stimulus kinds
   localparam logic [2:0] K_READ = 3'd0;
   localparam logic [2:0] K_WRITE = 3'd1;
   localparam logic [2:0] K_BURST = 3'd2;
   localparam logic [2:0] K_BAD = 3'd3;
   localparam logic [2:0] K_ILLEGAL = 3'd4;
   localparam logic [2:0] K_RST_WIN = 3'd5;

   // n_resp is the number of response bytes the entry must produce
   typedef struct packed {
      logic [2:0] kind;
      logic [3:0] addr;
      logic [7:0] data;
      logic       rnd;
      logic [1:0] n_resp;
   } entry_t;

   logic        clk;
   logic        rst;
   logic        uart_rxd;
   logic        uart_txd;
   logic        trap;
   logic [31:0] lfsr;
   logic [7:0]  model [soc_pkg::MEM_DEPTH];
   logic [7:0]  tx_bytes [$];
   logic [7:0]  exp_bytes [$];
   entry_t      table_q [$];
   int          errors;
   int          passed;
   int          failed;

   tb_clk_gen u_clk (.clk(clk));

   soc_fpga_wrapper u_dut (
      .clk      (clk),
      .rst      (rst),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_step(lfsr);
         b = {b[6:0], lfsr[0]};
      end
      return b;
   endfunction

   function automatic logic [7:0] header(input logic [3:0] op, input logic [3:0] addr);
      return {op, addr};
   endfunction

   function automatic string kind_name(input logic [2:0] kind);
      case (kind)
         K_READ:    return "read";
         K_WRITE:   return "write";
         K_BURST:   return "burst";
         K_BAD:     return "bad frame";
         K_ILLEGAL: return "illegal op";
         default:   return "reset window";
      endcase
   endfunction

   function automatic void clear_model();
      foreach (model[i]) begin
         model[i] = 8'h00;
      end
   endfunction

   function automatic void add_entry(input logic [2:0] kind, input int addr,
                                     input logic [7:0] data, input logic rnd, input int n_resp);
      entry_t e;
      e.kind = kind;
      e.addr = addr[3:0];
      e.data = data;
      e.rnd = rnd;
      e.n_resp = n_resp[1:0];
      table_q.push_back(e);
   endfunction

   function automatic void build_table();
      for (int a = 0; a < soc_pkg::MEM_DEPTH; a++) begin
         add_entry(K_READ, a, 8'h00, 1'b0, 1);
      end
      for (int a = 0; a < soc_pkg::MEM_DEPTH; a++) begin
         add_entry(K_WRITE, a, 8'h00, 1'b1, 1);
         add_entry(K_READ, a, 8'h00, 1'b0, 1);
      end
      // overwrites in scattered order
      for (int i = 0; i < 8; i++) begin
         add_entry(K_WRITE, (i * 7) % 16, 8'h00, 1'b1, 1);
         add_entry(K_READ, (i * 7) % 16, 8'h00, 1'b0, 1);
      end
      add_entry(K_BURST, 3, 8'h00, 1'b1, 3);
      add_entry(K_BURST, 15, 8'h00, 1'b1, 3);
      add_entry(K_BAD, 6, 8'h00, 1'b0, 0);
      add_entry(K_READ, 6, 8'h00, 1'b0, 1);
      add_entry(K_RST_WIN, 9, 8'h00, 1'b0, 0);
      add_entry(K_READ, 9, 8'h00, 1'b0, 1);
      add_entry(K_WRITE, 9, 8'h00, 1'b1, 1);
      add_entry(K_READ, 9, 8'h00, 1'b0, 1);
      // data holds the bad opcode
      add_entry(K_ILLEGAL, 4, 8'h07, 1'b0, 0);
      add_entry(K_READ, 4, 8'h00, 1'b0, 1);
      add_entry(K_WRITE, 1, 8'h00, 1'b1, 1);
      add_entry(K_ILLEGAL, 1, 8'h00, 1'b0, 0);
      add_entry(K_READ, 1, 8'h00, 1'b0, 1);
   endfunction

   task automatic send_byte(input logic [7:0] b, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, b, 1'b0};
      @(posedge clk);
      for (int i = 0; i < 10; i++) begin
         uart_rxd <= frame[i];
         repeat (BIT_CLKS) @(posedge clk);
      end
      // back to idle after a broken stop bit
      uart_rxd <= 1'b1;
   endtask

   task automatic recv_byte(output logic [7:0] b, output logic seen);
      int waited;
      b = '0;
      seen = 1'b0;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (uart_txd && waited < RESP_TIMEOUT);
      if (!uart_txd) begin
         seen = 1'b1;
         // middle of the start bit, then one bit time per sample
         repeat (BIT_CLKS / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = uart_txd;
         end
         repeat (BIT_CLKS) @(negedge clk);
         assert (uart_txd) else begin
            $display("** Error at %0t: stop bit low on uart_txd", $time);
            errors++;
         end
      end
   endtask

   task automatic expect_quiet(input int cycles);
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (uart_txd && waited < cycles);
      assert (uart_txd) else begin
         $display("unexpected response frame on uart_txd at time %0t", $time);
         errors++;
         repeat (FRAME_CLKS) @(negedge clk);
      end
   endtask

   task automatic wait_trap();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!trap && waited < RST_TIMEOUT);
      assert (trap) else begin
         $display("trap did not rise after an illegal opcode, time %0t", $time);
         errors++;
      end
   endtask

   task automatic wait_reset_done();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (u_dut.sys_rst && waited < RST_TIMEOUT);
      assert (!u_dut.sys_rst) else begin
         $display("system reset never released, time %0t", $time);
         errors++;
      end
   endtask

   task automatic pulse_reset(input int cycles);
      @(posedge clk);
      rst <= 1'b1;
      repeat (cycles) @(posedge clk);
      rst <= 1'b0;
   endtask

   // commands go out while responses come back
   task automatic exchange(input int n_resp);
      logic [7:0] got;
      logic       seen;
      fork
         begin
            foreach (tx_bytes[i]) begin
               send_byte(tx_bytes[i], 1'b1);
            end
         end
         begin
            for (int i = 0; i < n_resp; i++) begin
               recv_byte(got, seen);
               assert (seen) else begin
                  $display("no response byte %0d within timeout, time %0t", i, $time);
                  errors++;
               end
               assert (!seen || got == exp_bytes[i]) else begin
                  $display("** Error at %0t: response %0d is %02h, expected %02h",
                           $time, i, got, exp_bytes[i]);
                  errors++;
               end
            end
         end
      join
   endtask

   task automatic run_entry(input entry_t e);
      logic [7:0] d;
      logic [3:0] nxt;
      d = e.rnd ? rand_byte() : e.data;
      nxt = e.addr + 4'd1;
      tx_bytes.delete();
      exp_bytes.delete();
      case (e.kind)
         K_READ: begin
            tx_bytes.push_back(header(OP_RD, e.addr));
            exp_bytes.push_back(model[e.addr]);
         end
         K_WRITE: begin
            tx_bytes.push_back(header(OP_WR, e.addr));
            tx_bytes.push_back(d);
            model[e.addr] = d;
            exp_bytes.push_back(d);
         end
         K_BURST: begin
            tx_bytes.push_back(header(OP_WR, e.addr));
            tx_bytes.push_back(d);
            tx_bytes.push_back(header(OP_RD, e.addr));
            tx_bytes.push_back(header(OP_RD, nxt));
            model[e.addr] = d;
            exp_bytes.push_back(d);
            exp_bytes.push_back(model[e.addr]);
            exp_bytes.push_back(model[nxt]);
         end
         K_BAD: begin
            send_byte(header(OP_RD, e.addr), 1'b0);
         end
         K_RST_WIN: begin
            // frame ends after the pin falls but inside the hold window
            fork
               pulse_reset(FRAME_CLKS - soc_pkg::RST_HOLD / 2);
               send_byte(header(OP_RD, e.addr), 1'b1);
            join
            clear_model();
            wait_reset_done();
         end
         default: begin
            send_byte(header(e.data[3:0], e.addr), 1'b1);
            wait_trap();
            // halted engine ignores a read
            send_byte(header(OP_RD, e.addr), 1'b1);
            expect_quiet(RESP_TIMEOUT);
            pulse_reset(8);
            wait_reset_done();
            clear_model();
         end
      endcase
      exchange(int'(e.n_resp));
      expect_quiet(QUIET_CLKS);
      assert (!trap) else begin
         $display("** Error at %0t: trap high after %s", $time, kind_name(e.kind));
         errors++;
      end
   endtask

   initial begin
      int err_before;
      rst = 1'b1;
      uart_rxd = 1'b1;
      lfsr = 32'h85848c31;
      errors = 0;
      passed = 0;
      failed = 0;
      clear_model();
      build_table();
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      wait_reset_done();
      assert (uart_txd && !trap) else begin
         $display("** Error at %0t: line not idle or trap set after reset", $time);
         errors++;
      end
      foreach (table_q[t]) begin
         err_before = errors;
         run_entry(table_q[t]);
         if (errors == err_before) begin
            passed++;
            $display("test %0d %s addr %h: ok", t, kind_name(table_q[t].kind), table_q[t].addr);
         end else begin
            failed++;
            $display("test %0d %s addr %h: failed", t, kind_name(table_q[t].kind),
                     table_q[t].addr);
         end
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d", table_q.size(), passed, failed,
               errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_NS = 4
) (
   output logic clk
);

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

endmodule

//--- hdl/soc_fpga_wrapper.sv
`timescale 1ns/1ps

module soc_fpga_wrapper (
   input  logic clk,
   input  logic rst,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic trap
);

   logic       sys_rst;
   logic [7:0] rx_data;
   logic       rx_valid;
   logic [7:0] tx_data;
   logic       tx_start;
   logic       tx_busy;

   // board pin stretched into the system reset
   reset_stretch u_reset (
      .clk     (clk),
      .rst     (rst),
      .sys_rst (sys_rst)
   );

   uart_rx u_rx (
      .clk      (clk),
      .sys_rst  (sys_rst),
      .uart_rxd (uart_rxd),
      .rx_data  (rx_data),
      .rx_valid (rx_valid)
   );

   cmd_engine u_engine (
      .clk      (clk),
      .sys_rst  (sys_rst),
      .rx_data  (rx_data),
      .rx_valid (rx_valid),
      .tx_busy  (tx_busy),
      .tx_data  (tx_data),
      .tx_start (tx_start),
      .trap     (trap)
   );

   uart_tx u_tx (
      .clk      (clk),
      .sys_rst  (sys_rst),
      .tx_data  (tx_data),
      .tx_start (tx_start),
      .uart_txd (uart_txd),
      .tx_busy  (tx_busy)
   );

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic       clk,
   input  logic       sys_rst,
   input  logic [7:0] tx_data,
   input  logic       tx_start,
   output logic       uart_txd,
   output logic       tx_busy
);

   logic [9:0]                  frame;
   logic [soc_pkg::TICK_W-1:0]  tick;
   logic [3:0]                  bit_cnt;

   always_ff @(posedge clk) begin
      if (sys_rst) begin
         // all ones keeps the line idle
         frame   <= '1;
         tick    <= '0;
         bit_cnt <= '0;
         tx_busy <= 1'b0;
      end else if (tx_start && !tx_busy) begin
         // stop, data lsb first, start
         frame   <= {1'b1, tx_data, 1'b0};
         tick    <= '0;
         bit_cnt <= '0;
         tx_busy <= 1'b1;
      end else if (tx_busy) begin
         if (tick == soc_pkg::TICK_LAST) begin
            tick  <= '0;
            frame <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
               // stop bit done
               tx_busy <= 1'b0;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else begin
            tick <= tick + 1'b1;
         end
      end
   end

   assign uart_txd = frame[0];

   // start bit must follow an accepted start on the next cycle
   a_start_framing : assert property (
      @(posedge clk) disable iff (sys_rst)
         tx_start |-> !tx_busy ##1 (tx_busy && !uart_txd)
   ) else $error("tx_start while busy or start bit missing");

endmodule

//--- hdl/cmd_engine.sv
`timescale 1ns/1ps

module cmd_engine (
   input  logic       clk,
   input  logic       sys_rst,
   input  logic [7:0] rx_data,
   input  logic       rx_valid,
   input  logic       tx_busy,
   output logic [7:0] tx_data,
   output logic       tx_start,
   output logic       trap
);

   logic [7:0]                  mem [soc_pkg::MEM_DEPTH];
   logic [1:0]                  state;
   logic [soc_pkg::ADDR_W-1:0]  addr_q;
   logic                        pend_valid;
   logic [7:0]                  pend_data;
   logic                        resp_valid;
   logic [7:0]                  resp_data;

   soc_pkg::cmd_byte_t          cur_byte;
   logic                        cur_valid;
   logic                        tx_free;
   logic                        take;
   logic                        new_resp;
   logic [7:0]                  new_data;
   logic                        drain;
   logic                        send_new;
   logic                        queue_new;
   logic                        is_write;

   always_comb begin
      // pending byte is older than a fresh strobe
      cur_valid    = pend_valid || rx_valid;
      cur_byte.raw = pend_valid ? pend_data : rx_data;
      // tx_busy lags tx_start by one cycle
      tx_free      = !tx_busy && !tx_start;
      take         = cur_valid && (state != soc_pkg::ENG_HALT) && (!resp_valid || tx_free);
      is_write     = cur_byte.hdr.op == soc_pkg::OP_WRITE;
      new_resp     = 1'b0;
      new_data     = mem[cur_byte.hdr.addr];
      if (take) begin
         if (state == soc_pkg::ENG_HDR) begin
            new_resp = cur_byte.hdr.op == soc_pkg::OP_READ;
         end else begin
            // write payload is echoed back
            new_resp = 1'b1;
            new_data = cur_byte.raw;
         end
      end
      drain     = resp_valid && tx_free;
      send_new  = new_resp && tx_free && !resp_valid;
      queue_new = new_resp && !send_new;
   end

   // control state
   always_ff @(posedge clk) begin
      if (sys_rst) begin
         state      <= soc_pkg::ENG_HDR;
         trap       <= 1'b0;
         pend_valid <= 1'b0;
         resp_valid <= 1'b0;
         tx_start   <= 1'b0;
      end else begin
         tx_start <= drain || send_new;
         if (queue_new) begin
            resp_valid <= 1'b1;
         end else if (drain) begin
            resp_valid <= 1'b0;
         end
         if (state == soc_pkg::ENG_HALT) begin
            pend_valid <= 1'b0;
         end else if (take) begin
            pend_valid <= pend_valid && rx_valid;
         end else if (rx_valid) begin
            pend_valid <= 1'b1;
         end
         if (take) begin
            if (state == soc_pkg::ENG_PAY) begin
               state <= soc_pkg::ENG_HDR;
            end else if (is_write) begin
               state <= soc_pkg::ENG_PAY;
            end else if (cur_byte.hdr.op != soc_pkg::OP_READ) begin
               // unknown opcode, sticky until reset
               trap  <= 1'b1;
               state <= soc_pkg::ENG_HALT;
            end
         end
      end
   end

   // payload registers
   always_ff @(posedge clk) begin
      if (rx_valid && (take ? pend_valid : !pend_valid)) begin
         pend_data <= rx_data;
      end
      if (drain) begin
         tx_data <= resp_data;
      end else if (send_new) begin
         tx_data <= new_data;
      end
      if (queue_new) begin
         resp_data <= new_data;
      end
      if (take && state == soc_pkg::ENG_HDR && is_write) begin
         addr_q <= cur_byte.hdr.addr;
      end
   end

   // scratch memory, cleared by reset
   always_ff @(posedge clk) begin
      if (sys_rst) begin
         mem <= '{default: '0};
      end else if (take && state == soc_pkg::ENG_PAY) begin
         mem[addr_q] <= cur_byte.raw;
      end
   end

   a_start_idle : assert property (
      @(posedge clk) disable iff (sys_rst) tx_start |-> !tx_busy
   ) else $error("response launched while the transmitter is busy");

   a_trap_sticky : assert property (
      @(posedge clk) $fell(trap) |-> $past(sys_rst)
   ) else $error("trap cleared without reset");

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic       clk,
   input  logic       sys_rst,
   input  logic       uart_rxd,
   output logic [7:0] rx_data,
   output logic       rx_valid
);

   logic                        rxd_meta;
   logic                        rxd_sync;
   logic                        rxd_prev;
   logic [1:0]                  state;
   logic [soc_pkg::TICK_W-1:0]  tick;
   logic [2:0]                  bit_idx;
   logic [7:0]                  shift;

   // control path, line flops idle high
   always_ff @(posedge clk) begin
      if (sys_rst) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
         state    <= soc_pkg::RX_IDLE;
         tick     <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rxd_meta <= uart_rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
         rx_valid <= 1'b0;
         case (state)
            soc_pkg::RX_IDLE: begin
               // only a falling edge starts a frame
               if (rxd_prev && !rxd_sync) begin
                  state <= soc_pkg::RX_START;
                  tick  <= '0;
               end
            end
            soc_pkg::RX_START: begin
               if (tick == soc_pkg::TICK_MID) begin
                  tick    <= '0;
                  bit_idx <= '0;
                  // glitch shorter than half a bit goes back to idle
                  state   <= rxd_sync ? soc_pkg::RX_IDLE : soc_pkg::RX_DATA;
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            soc_pkg::RX_DATA: begin
               if (tick == soc_pkg::TICK_LAST) begin
                  tick <= '0;
                  if (bit_idx == 3'd7) begin
                     state <= soc_pkg::RX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  tick <= tick + 1'b1;
               end
            end
            default: begin
               if (tick == soc_pkg::TICK_LAST) begin
                  tick     <= '0;
                  state    <= soc_pkg::RX_IDLE;
                  // framing error drops the byte
                  rx_valid <= rxd_sync;
               end else begin
                  tick <= tick + 1'b1;
               end
            end
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk) begin
      if (state == soc_pkg::RX_DATA && tick == soc_pkg::TICK_LAST) begin
         shift <= {rxd_sync, shift[7:1]};
      end
      if (state == soc_pkg::RX_STOP && tick == soc_pkg::TICK_LAST && rxd_sync) begin
         rx_data <= shift;
      end
   end

   a_strobe_single : assert property (
      @(posedge clk) disable iff (sys_rst) rx_valid |=> !rx_valid
   ) else $error("rx_valid high on two consecutive cycles");

endmodule

//--- hdl/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch (
   input  logic clk,
   input  logic rst,
   output logic sys_rst
);

   logic [soc_pkg::RST_CNT_W-1:0] hold_cnt;

   // reload while the pin is held, then count down to zero
   always_ff @(posedge clk) begin
      if (rst) begin
         hold_cnt <= soc_pkg::RST_LOAD;
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

   // pin or remaining hold time
   assign sys_rst = rst || (hold_cnt != '0);

   // a pin cycle keeps the system in reset for the full hold time after it
   a_hold_after_pin : assert property (
      @(posedge clk) rst |-> sys_rst [*soc_pkg::RST_HOLD + 1]
   ) else $error("sys_rst released early after the reset pin");

endmodule

//--- hdl/soc_pkg.sv
package soc_pkg;

   // serial bit timing, shared by receiver and transmitter
   localparam int BIT_CLKS = 8;
   localparam int TICK_W = $clog2(BIT_CLKS);
   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(BIT_CLKS - 1);
   // last tick of the first half of the start bit
   localparam logic [TICK_W-1:0] TICK_MID = TICK_W'(BIT_CLKS / 2 - 1);

   // reset stretch length after the pin is released
   localparam int RST_HOLD = 16;
   localparam int RST_CNT_W = $clog2(RST_HOLD + 1);
   localparam logic [RST_CNT_W-1:0] RST_LOAD = RST_CNT_W'(RST_HOLD);

   // scratch memory
   localparam int MEM_DEPTH = 16;
   localparam int ADDR_W = $clog2(MEM_DEPTH);

   // opcodes in the upper nibble of a command header
   localparam logic [3:0] OP_WRITE = 4'h1;
   localparam logic [3:0] OP_READ = 4'h2;

   // receiver states
   localparam logic [1:0] RX_IDLE = 2'd0;
   localparam logic [1:0] RX_START = 2'd1;
   localparam logic [1:0] RX_DATA = 2'd2;
   localparam logic [1:0] RX_STOP = 2'd3;

   // command engine states
   localparam logic [1:0] ENG_HDR = 2'd0;
   localparam logic [1:0] ENG_PAY = 2'd1;
   localparam logic [1:0] ENG_HALT = 2'd2;

   // a received byte, seen as header or as raw payload
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [3:0] op;
         logic [3:0] addr;
      } hdr;
   } cmd_byte_t;

endpackage
